// ==== hw/loader_defines.svh ====
`ifndef LOADER_DEFINES_SVH
`define LOADER_DEFINES_SVH

// Data word width in bits
`define WORD_WIDTH 32

// Words per storage sector, one sector is 4096 bits
`define SECTOR_WORDS 128

// Sectors held by the block store
`define SECTOR_COUNT 4

// Program RAM depth in words
`define RAM_WORDS 256

// Cycles from read request to sector ready
`define READ_LATENCY 6

`endif

// ==== hw/loaderPkg.sv ====
`include "loader_defines.svh"

package loaderPkg;

    // Loader FSM states
    typedef enum logic [2:0] {
        LoadIdle,
        LoadRequest,
        LoadWait,
        LoadWrite,
        LoadDone
    } loaderState;

    // Read request towards the sector store, strobe is one cycle
    typedef struct packed {
        logic                                strobe;
        logic [$clog2(`SECTOR_COUNT)-1:0]    sector;
    } sectorRequest;

    // Whole sector returned after the fixed latency
    typedef struct packed {
        logic                                    ready;
        logic [`SECTOR_WORDS*`WORD_WIDTH-1:0]    data; // Word 0 in the low bits
    } sectorResponse;

    // One word per cycle into program RAM
    typedef struct packed {
        logic                             enable;
        logic [$clog2(`RAM_WORDS)-1:0]    address;
        logic [`WORD_WIDTH-1:0]           data;
    } ramWrite;

endpackage

// ==== hw/sectorStore.sv ====
`include "loader_defines.svh"

// Stand-in for the card controller, answers a sector read after READ_LATENCY cycles
module sectorStore (
    input  logic                                Clock,
    input  logic                                Reset,
    input  logic                                FillStrobe,
    input  logic [$clog2(`SECTOR_COUNT)-1:0]    FillSector,
    input  logic [$clog2(`SECTOR_WORDS)-1:0]    FillWord,
    input  logic [`WORD_WIDTH-1:0]              FillData,
    input  loaderPkg::sectorRequest             request,
    output loaderPkg::sectorResponse            response,
    output logic                                Busy
);

    localparam int sectorBits  = `SECTOR_WORDS * `WORD_WIDTH;
    localparam int latencyBits = $clog2(`READ_LATENCY + 1);

    logic [sectorBits-1:0]               sectors [`SECTOR_COUNT];
    logic [sectorBits-1:0]               sectorData;
    logic [$clog2(`SECTOR_COUNT)-1:0]    readIndex;
    logic [latencyBits-1:0]              latencyCount;
    logic                                readyReg;
    logic                                finishing;
    logic                                acceptRequest;

    assign acceptRequest = request.strobe && !Busy; // Requests during a read are dropped
    assign finishing     = Busy && (latencyCount == latencyBits'(1));

    // Control path
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            Busy         <= 1'b0;
            readyReg     <= 1'b0;
            readIndex    <= '0;
            latencyCount <= '0;
        end else begin
            readyReg <= finishing; // Ready lands in the last busy cycle
            if (acceptRequest) begin
                Busy         <= 1'b1;
                readIndex    <= request.sector;
                latencyCount <= latencyBits'(`READ_LATENCY - 1);
            end else if (Busy) begin
                if (latencyCount != '0) begin
                    latencyCount <= latencyCount - 1'b1;
                end
                if (readyReg) begin
                    Busy <= 1'b0; // Read finished
                end
            end
        end
    end

    // Sector memory, written a word at a time from outside
    always_ff @(posedge Clock) begin
        if (FillStrobe) begin
            sectors[FillSector][FillWord*`WORD_WIDTH +: `WORD_WIDTH] <= FillData;
        end
    end

    // Whole sector picked up one cycle before ready
    always_ff @(posedge Clock) begin
        if (finishing) begin
            sectorData <= sectors[readIndex];
        end
    end

    assign response = '{ready: readyReg, data: sectorData};

endmodule

// ==== hw/programLoader.sv ====
`include "loader_defines.svh"

module programLoader (
    input  logic                        Clock,
    input  logic                        Reset,
    input  logic                        Start,
    output loaderPkg::sectorRequest     request,
    input  loaderPkg::sectorResponse    response,
    output loaderPkg::ramWrite          ramPort,
    output logic                        LoadDone,
    output logic                        Truncated
);

    import loaderPkg::*;

    localparam int sectorBits  = `SECTOR_WORDS * `WORD_WIDTH;
    localparam int addressBits = $clog2(`RAM_WORDS);
    localparam int countBits   = $clog2(`RAM_WORDS + 1); // Must hold RAM_WORDS itself

    loaderState                          state;
    logic [sectorBits-1:0]               shiftData;
    logic [$clog2(`SECTOR_WORDS)-1:0]    wordCount;
    logic [$clog2(`SECTOR_COUNT)-1:0]    sectorIndex;
    logic [countBits-1:0]                writtenCount;
    logic [countBits-1:0]                effectiveLength;
    logic [`WORD_WIDTH-1:0]              currentWord;
    logic                                headerWord;
    logic                                lastWordInSector;
    logic                                lastWrite;
    logic                                writeNow;

    assign currentWord      = shiftData[`WORD_WIDTH-1:0]; // Bottom of the shift register
    assign headerWord       = (sectorIndex == '0) && (wordCount == '0);
    assign lastWordInSector = (wordCount == '1);
    assign lastWrite        = (writtenCount + 1'b1) == effectiveLength;
    assign writeNow         = (state == LoadWrite) && !headerWord;

    // The port owns the name LoadDone, so the state literal is scoped
    assign LoadDone = (state == loaderPkg::LoadDone);

    assign request = '{strobe: (state == LoadRequest), sector: sectorIndex};

    assign ramPort = '{
        enable:  writeNow,
        address: writtenCount[addressBits-1:0],
        data:    currentWord
    };

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state           <= LoadIdle;
            sectorIndex     <= '0;
            wordCount       <= '0;
            writtenCount    <= '0;
            effectiveLength <= '0;
            Truncated       <= 1'b0;
        end else begin
            case (state)
                LoadIdle, loaderPkg::LoadDone: begin
                    if (Start) begin
                        state        <= LoadRequest;
                        sectorIndex  <= '0;
                        wordCount    <= '0;
                        writtenCount <= '0;
                        Truncated    <= 1'b0;
                    end
                end
                LoadRequest: begin
                    state <= LoadWait; // Strobe goes out this cycle
                end
                LoadWait: begin
                    if (response.ready) begin
                        state <= LoadWrite;
                    end
                end
                LoadWrite: begin
                    wordCount <= wordCount + 1'b1; // Wraps to 0 after word 127
                    if (headerWord) begin
                        // Clip the length to the RAM once, here
                        if (currentWord > `RAM_WORDS) begin
                            effectiveLength <= countBits'(`RAM_WORDS);
                            Truncated       <= 1'b1;
                        end else begin
                            effectiveLength <= currentWord[countBits-1:0];
                        end
                        if (currentWord == '0) begin
                            state <= loaderPkg::LoadDone; // Empty image
                        end
                    end else begin
                        writtenCount <= writtenCount + 1'b1;
                        if (lastWrite) begin
                            state <= loaderPkg::LoadDone;
                        end else if (lastWordInSector) begin
                            state       <= LoadRequest;
                            sectorIndex <= sectorIndex + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= LoadIdle;
                end
            endcase
        end
    end

    // Sector payload, shifted down a word per write cycle
    always_ff @(posedge Clock) begin
        if ((state == LoadWait) && response.ready) begin
            shiftData <= response.data;
        end else if (state == LoadWrite) begin
            shiftData <= shiftData >> `WORD_WIDTH;
        end
    end

endmodule

// ==== hw/programRam.sv ====
`include "loader_defines.svh"

module programRam (
    input  logic                             Clock,
    input  loaderPkg::ramWrite               ramPort,
    input  logic [$clog2(`RAM_WORDS)-1:0]    ReadAddress,
    output logic [`WORD_WIDTH-1:0]           ReadData
);

    logic [`WORD_WIDTH-1:0] memory [`RAM_WORDS]; // Keeps its contents across loads

    // Write port from the loader
    always_ff @(posedge Clock) begin
        if (ramPort.enable) begin
            memory[ramPort.address] <= ramPort.data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge Clock) begin
        ReadData <= memory[ReadAddress];
    end

endmodule

// ==== hw/bootSubsystem.sv ====
`include "loader_defines.svh"

module bootSubsystem (
    input  logic                                Clock,
    input  logic                                Reset,
    input  logic                                Start,
    input  logic                                FillStrobe,
    input  logic [$clog2(`SECTOR_COUNT)-1:0]    FillSector,
    input  logic [$clog2(`SECTOR_WORDS)-1:0]    FillWord,
    input  logic [`WORD_WIDTH-1:0]              FillData,
    input  logic [$clog2(`RAM_WORDS)-1:0]       ReadAddress,
    output logic [`WORD_WIDTH-1:0]              ReadData,
    output logic                                LoadDone,
    output logic                                Truncated,
    output logic                                Busy
);

    import loaderPkg::*;

    sectorRequest  storeRequest;
    sectorResponse storeResponse;
    ramWrite       ramPort;

    sectorStore store (
        .Clock      (Clock),
        .Reset      (Reset),
        .FillStrobe (FillStrobe),
        .FillSector (FillSector),
        .FillWord   (FillWord),
        .FillData   (FillData),
        .request    (storeRequest),
        .response   (storeResponse),
        .Busy       (Busy) // Observation only
    );

    programLoader loader (
        .Clock     (Clock),
        .Reset     (Reset),
        .Start     (Start),
        .request   (storeRequest),
        .response  (storeResponse),
        .ramPort   (ramPort),
        .LoadDone  (LoadDone),
        .Truncated (Truncated)
    );

    programRam ram (
        .Clock       (Clock),
        .ramPort     (ramPort),
        .ReadAddress (ReadAddress),
        .ReadData    (ReadData)
    );

endmodule

// ==== verification/bootSubsystemTb.sv ====
`include "loader_defines.svh"

module bootSubsystemTb;

    localparam int imageWords      = `SECTOR_COUNT * `SECTOR_WORDS;
    localparam int sectorIndexBits = $clog2(`SECTOR_COUNT);
    localparam int wordIndexBits   = $clog2(`SECTOR_WORDS);
    localparam int addressBits     = $clog2(`RAM_WORDS);
    localparam int tableLength     = 5;

    // Worst case per test with a factor of two for margin
    localparam int cycleLimit = tableLength *
        (`SECTOR_COUNT * (`SECTOR_WORDS + `READ_LATENCY + 4) + 256 + 260) * 2;

    typedef struct packed {
        logic [31:0] length;    // Header value N
        logic        truncated; // Expected Truncated after the load
        logic [8:0]  readCount; // RAM words checked from address 0 up
    } testEntry;

    logic                          Clock;
    logic                          Reset;
    logic                          Start;
    logic                          FillStrobe;
    logic [sectorIndexBits-1:0]    FillSector;
    logic [wordIndexBits-1:0]      FillWord;
    logic [`WORD_WIDTH-1:0]        FillData;
    logic [addressBits-1:0]        ReadAddress;
    logic [`WORD_WIDTH-1:0]        ReadData;
    logic                          LoadDone;
    logic                          Truncated;
    logic                          Busy;

    logic [`WORD_WIDTH-1:0] image    [imageWords]; // Store contents with the header in word 0
    logic [`WORD_WIDTH-1:0] ramModel [`RAM_WORDS]; // What the RAM should hold by now

    integer seed;
    int     checkCount;
    int     errorCount;
    int     testErrors;

    testEntry testTable [tableLength] = '{
        '{32'd20,  1'b0, 9'd20},  // Fits in sector 0
        '{32'd200, 1'b0, 9'd200}, // Crosses into sector 1
        '{32'd0,   1'b0, 9'd4},   // Empty image leaves old words
        '{32'd500, 1'b1, 9'd256}, // Larger than the RAM
        '{32'd10,  1'b0, 9'd11}   // Reload leaves address 10 alone
    };

    bootSubsystem uut (
        .Clock       (Clock),
        .Reset       (Reset),
        .Start       (Start),
        .FillStrobe  (FillStrobe),
        .FillSector  (FillSector),
        .FillWord    (FillWord),
        .FillData    (FillData),
        .ReadAddress (ReadAddress),
        .ReadData    (ReadData),
        .LoadDone    (LoadDone),
        .Truncated   (Truncated),
        .Busy        (Busy)
    );

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    // Watchdog for a stalled load
    initial begin
        int cycleCount;
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge Clock);
            cycleCount++;
        end
        $display("Timeout waiting for LoadDone after %0d cycles", cycleLimit);
        $display("ERRORS FOUND");
        $finish;
    end

    // Inputs change 1 unit after the rising edge
    task automatic nextCycle;
        @(posedge Clock);
        #1;
    endtask

    task automatic checkWord(input string signalName, input logic [31:0] expected,
                             input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            testErrors++;
            $display("** Error at time %0t: %s expected %h, got %h",
                     $time, signalName, expected, actual);
        end
    endtask

    task automatic buildImage(input logic [31:0] length);
        image[0] = length;
        for (int i = 1; i < imageWords; i++) begin
            image[i] = $random(seed);
        end
    endtask

    // Whole store one word per cycle
    task automatic fillStore;
        for (int i = 0; i < imageWords; i++) begin
            FillStrobe = 1'b1;
            FillSector = sectorIndexBits'(i / `SECTOR_WORDS);
            FillWord   = wordIndexBits'(i % `SECTOR_WORDS);
            FillData   = image[i];
            nextCycle();
        end
        FillStrobe = 1'b0;
    endtask

    task automatic pulseStart;
        Start = 1'b1;
        nextCycle();
        Start = 1'b0;
    endtask

    task automatic waitForDone(output int busyCycles);
        busyCycles = 0;
        while (!LoadDone) begin
            nextCycle();
            if (Busy) begin
                busyCycles++;
            end
        end
    endtask

    // Header plus payload words, rounded up to whole sectors
    function automatic int sectorReads(input logic [31:0] length);
        int loadCount;
        loadCount = (length > `RAM_WORDS) ? `RAM_WORDS : int'(length);
        return (loadCount + `SECTOR_WORDS) / `SECTOR_WORDS;
    endfunction

    // Payload word a+1 lands at address a up to the RAM depth
    task automatic updateModel(input logic [31:0] length);
        int loadCount;
        loadCount = (length > `RAM_WORDS) ? `RAM_WORDS : int'(length);
        for (int a = 0; a < loadCount; a++) begin
            ramModel[a] = image[a + 1];
        end
    endtask

    task automatic readBack(input int count);
        for (int a = 0; a < count; a++) begin
            ReadAddress = addressBits'(a);
            nextCycle(); // Registered read
            checkWord($sformatf("ReadData[%0d]", a), ramModel[a], ReadData);
        end
    endtask

    initial begin
        testEntry entry;
        int       busyCycles;
        seed        = 32'ha819713e;
        Reset       = 1'b1;
        Start       = 1'b0;
        FillStrobe  = 1'b0;
        FillSector  = '0;
        FillWord    = '0;
        FillData    = '0;
        ReadAddress = '0;
        checkCount  = 0;
        errorCount  = 0;
        testErrors  = 0;

        repeat (2) nextCycle();
        Reset = 1'b0;
        nextCycle();

        // Quiet outputs out of reset
        checkWord("LoadDone after reset", 32'd0, LoadDone);
        checkWord("Truncated after reset", 32'd0, Truncated);
        checkWord("Busy after reset", 32'd0, Busy);

        for (int t = 0; t < tableLength; t++) begin
            entry      = testTable[t];
            testErrors = 0;
            buildImage(entry.length);
            fillStore();
            pulseStart();
            checkWord("LoadDone after Start", 32'd0, LoadDone); // Old done must drop
            checkWord("Truncated after Start", 32'd0, Truncated);
            waitForDone(busyCycles);
            checkWord("Truncated", 32'(entry.truncated), Truncated);
            checkWord("Busy cycles", 32'(sectorReads(entry.length) * `READ_LATENCY),
                      32'(busyCycles)); // Busy spans each read latency
            updateModel(entry.length);
            readBack(int'(entry.readCount));
            $display("Test %0d: N=%0d, %0d words read back, %0d mismatches, %s",
                     t + 1, entry.length, entry.readCount, testErrors,
                     (testErrors == 0) ? "passed" : "failed");
        end

        $display("Tests run: %0d, checks: %0d, errors: %0d",
                 tableLength, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/loaderPkg.sv
hw/sectorStore.sv
hw/programLoader.sv
hw/programRam.sv
hw/bootSubsystem.sv
verification/bootSubsystemTb.sv

// ==== Makefile ====
TOP := bootSubsystemTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
